/* source/isa_pkg.sv */
`default_nettype none

// instruction-set view of the operand path
package isa_pkg;

    localparam int XLEN   = 32; // data path width
    localparam int REG_AW = 5;  // 32 architectural registers

    // opcodes as delivered by the decoder
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        ADDI = 4'd5, // rs1 + imm
        LW   = 4'd6,
        SW   = 4'd7,
        JAL  = 4'd8, // rd <= pc + 4 without redirect
        NOP  = 4'd15
    } op_e;

endpackage

`default_nettype wire

/* source/pipe_pkg.sv */
`default_nettype none

// pipeline control encodings shared by execute, forwarding and writeback
package pipe_pkg;

    // where the value written to rd comes from
    typedef enum logic [1:0] {
        ALU = 2'd0, // alu result
        MEM = 2'd1, // load data
        PC  = 2'd2  // pc + 4 of a jal
    } wb_src_e;

endpackage

`default_nettype wire

/* source/reg_file.sv */
`default_nettype none

module reg_file (
    input  wire                         clk_i,
    input  wire                         arst_n_i,
    input  wire  [isa_pkg::REG_AW-1:0]  rd_addr1_i,
    input  wire  [isa_pkg::REG_AW-1:0]  rd_addr2_i,
    output logic [isa_pkg::XLEN-1:0]    rd_data1_o,
    output logic [isa_pkg::XLEN-1:0]    rd_data2_o,
    input  wire                         wr_en_i,
    input  wire  [isa_pkg::REG_AW-1:0]  wr_addr_i,
    input  wire  [isa_pkg::XLEN-1:0]    wr_data_i
);

    localparam int NREGS = 2 ** isa_pkg::REG_AW;

    logic [isa_pkg::XLEN-1:0] regs [1:NREGS-1]; // x0 is not stored

    // one read port with the pending write bypassed in
    function automatic logic [isa_pkg::XLEN-1:0] read_port(
        input logic [isa_pkg::REG_AW-1:0] addr
    );
        logic [isa_pkg::XLEN-1:0] val;
        if (addr == '0) begin
            val = '0;
        end else if (wr_en_i && (wr_addr_i == addr)) begin
            val = wr_data_i; // write-through
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        rd_data1_o = read_port(rd_addr1_i);
        rd_data2_o = read_port(rd_addr2_i);
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // the top clears the write enable at issue when rd is x0
    a_no_x0_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wr_en_i |-> (wr_addr_i != '0))
        else $error("register file write to x0 with enable set");

endmodule

`default_nettype wire

/* source/load_use_guard.sv */
`default_nettype none

module load_use_guard (
    input  wire                         clk_i,
    input  wire                         arst_n_i,
    input  wire                         ex_valid_i,
    input  wire isa_pkg::op_e           ex_op_i,
    input  wire  [isa_pkg::REG_AW-1:0]  ex_rd_i,
    input  wire                         issue_valid_i,
    input  wire  [isa_pkg::REG_AW-1:0]  issue_rs1_i,
    input  wire  [isa_pkg::REG_AW-1:0]  issue_rs2_i,
    output logic                        stall_o
);

    logic ex_is_load;
    logic src_hit;

    // a load to x0 produces nothing to wait for
    assign ex_is_load = ex_valid_i && (ex_op_i == isa_pkg::LW) && (ex_rd_i != '0);
    assign src_hit    = (ex_rd_i == issue_rs1_i) || (ex_rd_i == issue_rs2_i);

    assign stall_o = ex_is_load && issue_valid_i && src_hit;

    // the bubble pushes the load on, so the hazard clears after one cycle
    a_single_stall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        stall_o |=> !stall_o)
        else $error("load-use stall held for more than one cycle");

endmodule

`default_nettype wire

/* source/forward_controller.sv */
`default_nettype none

module forward_controller (
    input  wire  [isa_pkg::REG_AW-1:0]  reg_addr1_i,
    input  wire  [isa_pkg::XLEN-1:0]    reg_rs1_i,
    input  wire  [isa_pkg::REG_AW-1:0]  reg_addr2_i,
    input  wire  [isa_pkg::XLEN-1:0]    reg_rs2_i,

    input  wire  [isa_pkg::REG_AW-1:0]  ex_mem_reg_wr_addr_i,
    input  wire                         ex_mem_reg_wr_sig_i,
    input  wire pipe_pkg::wb_src_e      ex_mem_data_dest_i,
    input  wire  [isa_pkg::XLEN-1:0]    ex_mem_alu_result_i,
    input  wire  [isa_pkg::XLEN-1:0]    ex_mem_pc_plus4_i,

    input  wire  [isa_pkg::REG_AW-1:0]  mem_wb_reg_wr_addr_i,
    input  wire                         mem_wb_reg_wr_sig_i,
    input  wire pipe_pkg::wb_src_e      mem_wb_data_dest_i,
    input  wire  [isa_pkg::XLEN-1:0]    mem_wb_mem_rd_data_i,
    input  wire  [isa_pkg::XLEN-1:0]    mem_wb_alu_result_i,
    input  wire  [isa_pkg::XLEN-1:0]    mem_wb_pc_plus4_i,

    output logic [isa_pkg::XLEN-1:0]    rs1_o,
    output logic [isa_pkg::XLEN-1:0]    rs2_o
);

    logic [isa_pkg::XLEN-1:0] ex_mem_val;
    logic [isa_pkg::XLEN-1:0] mem_wb_val;

    // value each stage would write back
    assign ex_mem_val = (ex_mem_data_dest_i == pipe_pkg::PC) ? ex_mem_pc_plus4_i
                                                               : ex_mem_alu_result_i;

    always_comb begin
        case (mem_wb_data_dest_i)
            pipe_pkg::MEM: mem_wb_val = mem_wb_mem_rd_data_i;
            pipe_pkg::PC:  mem_wb_val = mem_wb_pc_plus4_i;
            default:       mem_wb_val = mem_wb_alu_result_i;
        endcase
    end

    // newest producer wins and x0 is never forwarded
    function automatic logic [isa_pkg::XLEN-1:0] pick(
        input logic [isa_pkg::REG_AW-1:0] addr,
        input logic [isa_pkg::XLEN-1:0]   reg_val
    );
        logic ex_hit;
        logic wb_hit;
        logic [isa_pkg::XLEN-1:0] val;
        // load data is not ready in ex/mem so the guard stalls that case
        ex_hit = ex_mem_reg_wr_sig_i && (ex_mem_reg_wr_addr_i == addr) &&
                 (addr != '0) && (ex_mem_data_dest_i != pipe_pkg::MEM);
        wb_hit = mem_wb_reg_wr_sig_i && (mem_wb_reg_wr_addr_i == addr) && (addr != '0);
        if (ex_hit) begin
            val = ex_mem_val;
        end else if (wb_hit) begin
            val = mem_wb_val;
        end else begin
            val = reg_val;
        end
        return val;
    endfunction

    always_comb begin
        rs1_o = pick(reg_addr1_i, reg_rs1_i);
        rs2_o = pick(reg_addr2_i, reg_rs2_i);
    end

endmodule

`default_nettype wire

/* source/exec_unit.sv */
`default_nettype none

module exec_unit (
    input  wire isa_pkg::op_e           op_i,
    input  wire  [isa_pkg::XLEN-1:0]    rs1_i,
    input  wire  [isa_pkg::XLEN-1:0]    rs2_i,
    input  wire  [isa_pkg::XLEN-1:0]    imm_i,
    input  wire  [isa_pkg::XLEN-1:0]    pc_i,
    output logic [isa_pkg::XLEN-1:0]    result_o,
    output logic [isa_pkg::XLEN-1:0]    store_data_o,
    output pipe_pkg::wb_src_e           wb_src_o,
    output logic                        reg_wr_o,
    output logic                        mem_wr_o
);

    logic [isa_pkg::XLEN-1:0] addr_sum;

    assign addr_sum     = rs1_i + imm_i; // shared by addi, lw, sw
    assign store_data_o = rs2_i;

    always_comb begin
        result_o = addr_sum;
        wb_src_o = pipe_pkg::ALU;
        reg_wr_o = 1'b1;
        mem_wr_o = 1'b0;
        case (op_i)
            isa_pkg::ADD: result_o = rs1_i + rs2_i;
            isa_pkg::SUB: result_o = rs1_i - rs2_i;
            isa_pkg::AND: result_o = rs1_i & rs2_i;
            isa_pkg::OR:  result_o = rs1_i | rs2_i;
            isa_pkg::XOR: result_o = rs1_i ^ rs2_i;
            isa_pkg::ADDI: result_o = addr_sum;
            isa_pkg::LW: begin
                wb_src_o = pipe_pkg::MEM;
            end
            isa_pkg::SW: begin
                reg_wr_o = 1'b0;
                mem_wr_o = 1'b1;
            end
            isa_pkg::JAL: begin
                result_o = pc_i + 32'd4; // link only
                wb_src_o = pipe_pkg::PC;
            end
            default: begin
                reg_wr_o = 1'b0; // nop
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/data_mem.sv */
`default_nettype none

module data_mem #(
    parameter int DMEM_WORDS = 64
) (
    input  wire                         clk_i,
    input  wire                         arst_n_i,
    input  wire  [isa_pkg::XLEN-1:0]    addr_i,
    input  wire                         wr_en_i,
    input  wire  [isa_pkg::XLEN-1:0]    wr_data_i,
    output logic [isa_pkg::XLEN-1:0]    rd_data_o
);

    localparam int IDX_W = $clog2(DMEM_WORDS);

    logic [isa_pkg::XLEN-1:0] mem [DMEM_WORDS];
    logic [IDX_W-1:0]         word_idx;

    assign word_idx = addr_i[IDX_W+1:2]; // wraps modulo depth

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
            rd_data_o <= '0;
        end else begin
            if (wr_en_i) begin
                mem[word_idx] <= wr_data_i;
            end
            rd_data_o <= mem[word_idx]; // one cycle read
        end
    end

    // the top parks the address at zero unless a lw or sw is in ex/mem
    a_word_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        addr_i[1:0] == 2'b00)
        else $error("misaligned data memory access");

endmodule

`default_nettype wire

/* source/operand_pipeline.sv */
`default_nettype none

module operand_pipeline #(
    parameter int DMEM_WORDS = 64
) (
    input  wire                         clk_i,
    input  wire                         arst_n_i,
    input  wire                         issue_valid_i,
    input  wire isa_pkg::op_e           issue_op_i,
    input  wire  [isa_pkg::REG_AW-1:0]  issue_rs1_i,
    input  wire  [isa_pkg::REG_AW-1:0]  issue_rs2_i,
    input  wire  [isa_pkg::REG_AW-1:0]  issue_rd_i,
    input  wire  [isa_pkg::XLEN-1:0]    issue_imm_i,
    input  wire  [isa_pkg::XLEN-1:0]    issue_pc_i,
    output logic                        issue_stall_o,
    output logic                        retire_valid_o,
    output logic [isa_pkg::REG_AW-1:0]  retire_rd_o,
    output logic [isa_pkg::XLEN-1:0]    retire_data_o
);

    localparam int XW = isa_pkg::XLEN;
    localparam int AW = isa_pkg::REG_AW;

    logic          issue_accept;
    logic [XW-1:0] rf_rd1;
    logic [XW-1:0] rf_rd2;

    logic          id_ex_valid;
    logic          id_ex_wr_ok;
    isa_pkg::op_e  id_ex_op;
    logic [AW-1:0] id_ex_rs1, id_ex_rs2, id_ex_rd;
    logic [XW-1:0] id_ex_rs1_val, id_ex_rs2_val, id_ex_imm, id_ex_pc;

    logic [XW-1:0]     fwd_rs1, fwd_rs2;
    logic [XW-1:0]     exu_result, exu_store_data;
    pipe_pkg::wb_src_e exu_wb_src;
    logic              exu_reg_wr, exu_mem_wr;

    logic              ex_mem_valid, ex_mem_reg_wr, ex_mem_mem_wr;
    pipe_pkg::wb_src_e ex_mem_wb_src;
    logic [AW-1:0]     ex_mem_rd;
    logic [XW-1:0]     ex_mem_result, ex_mem_store_data, ex_mem_pc4;

    logic              mem_wb_valid, mem_wb_reg_wr;
    pipe_pkg::wb_src_e mem_wb_wb_src;
    logic [AW-1:0]     mem_wb_rd;
    logic [XW-1:0]     mem_wb_result, mem_wb_pc4;

    logic [XW-1:0] dmem_addr, dmem_rd_data, wb_data;
    logic          wb_we;

    assign issue_accept = issue_valid_i && !issue_stall_o;

    reg_file u_reg_file (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .rd_addr1_i(issue_rs1_i), .rd_addr2_i(issue_rs2_i),
        .rd_data1_o(rf_rd1), .rd_data2_o(rf_rd2),
        .wr_en_i(wb_we), .wr_addr_i(mem_wb_rd), .wr_data_i(wb_data)
    );

    load_use_guard u_load_use_guard (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .ex_valid_i(id_ex_valid), .ex_op_i(id_ex_op), .ex_rd_i(id_ex_rd),
        .issue_valid_i(issue_valid_i), .issue_rs1_i(issue_rs1_i),
        .issue_rs2_i(issue_rs2_i), .stall_o(issue_stall_o)
    );

    // a stall or an idle cycle loads a bubble into id/ex
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_valid <= 1'b0;
            id_ex_wr_ok <= 1'b0;
        end else begin
            id_ex_valid <= issue_accept;
            id_ex_wr_ok <= issue_accept && (issue_rd_i != '0); // x0 never written
        end
    end

    always_ff @(posedge clk_i) begin
        id_ex_op      <= issue_op_i;
        id_ex_rs1     <= issue_rs1_i;
        id_ex_rs2     <= issue_rs2_i;
        id_ex_rd      <= issue_rd_i;
        id_ex_rs1_val <= rf_rd1;
        id_ex_rs2_val <= rf_rd2;
        id_ex_imm     <= issue_imm_i;
        id_ex_pc      <= issue_pc_i;
    end

    forward_controller u_forward_controller (
        .reg_addr1_i(id_ex_rs1), .reg_rs1_i(id_ex_rs1_val),
        .reg_addr2_i(id_ex_rs2), .reg_rs2_i(id_ex_rs2_val),
        .ex_mem_reg_wr_addr_i(ex_mem_rd), .ex_mem_reg_wr_sig_i(ex_mem_reg_wr),
        .ex_mem_data_dest_i(ex_mem_wb_src), .ex_mem_alu_result_i(ex_mem_result),
        .ex_mem_pc_plus4_i(ex_mem_pc4),
        .mem_wb_reg_wr_addr_i(mem_wb_rd), .mem_wb_reg_wr_sig_i(mem_wb_reg_wr),
        .mem_wb_data_dest_i(mem_wb_wb_src), .mem_wb_mem_rd_data_i(dmem_rd_data),
        .mem_wb_alu_result_i(mem_wb_result), .mem_wb_pc_plus4_i(mem_wb_pc4),
        .rs1_o(fwd_rs1), .rs2_o(fwd_rs2)
    );

    exec_unit u_exec_unit (
        .op_i(id_ex_op), .rs1_i(fwd_rs1), .rs2_i(fwd_rs2),
        .imm_i(id_ex_imm), .pc_i(id_ex_pc),
        .result_o(exu_result), .store_data_o(exu_store_data),
        .wb_src_o(exu_wb_src), .reg_wr_o(exu_reg_wr), .mem_wr_o(exu_mem_wr)
    );

    // ex/mem and mem/wb control
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_mem_valid  <= 1'b0;
            ex_mem_reg_wr <= 1'b0;
            ex_mem_mem_wr <= 1'b0;
            ex_mem_wb_src <= pipe_pkg::ALU;
            mem_wb_valid  <= 1'b0;
            mem_wb_reg_wr <= 1'b0;
            mem_wb_wb_src <= pipe_pkg::ALU;
        end else begin
            ex_mem_valid  <= id_ex_valid;
            ex_mem_reg_wr <= id_ex_wr_ok && exu_reg_wr;
            ex_mem_mem_wr <= id_ex_valid && exu_mem_wr;
            ex_mem_wb_src <= exu_wb_src;
            mem_wb_valid  <= ex_mem_valid;
            mem_wb_reg_wr <= ex_mem_reg_wr;
            mem_wb_wb_src <= ex_mem_wb_src;
        end
    end

    always_ff @(posedge clk_i) begin
        ex_mem_rd         <= id_ex_rd;
        ex_mem_result     <= exu_result;
        ex_mem_store_data <= exu_store_data;
        ex_mem_pc4        <= id_ex_pc + 32'd4;
        mem_wb_rd         <= ex_mem_rd;
        mem_wb_result     <= ex_mem_result;
        mem_wb_pc4        <= ex_mem_pc4;
    end

    // only a real lw or sw drives the memory address
    assign dmem_addr = (ex_mem_valid && (ex_mem_mem_wr || ex_mem_wb_src == pipe_pkg::MEM))
                       ? ex_mem_result : '0;

    data_mem #(
        .DMEM_WORDS(DMEM_WORDS)
    ) u_data_mem (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .addr_i(dmem_addr), .wr_en_i(ex_mem_mem_wr),
        .wr_data_i(ex_mem_store_data), .rd_data_o(dmem_rd_data)
    );

    always_comb begin
        case (mem_wb_wb_src)
            pipe_pkg::MEM: wb_data = dmem_rd_data;
            pipe_pkg::PC:  wb_data = mem_wb_pc4;
            default:       wb_data = mem_wb_result;
        endcase
    end

    assign wb_we = mem_wb_valid && mem_wb_reg_wr;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retire_valid_o <= 1'b0;
            retire_rd_o    <= '0;
            retire_data_o  <= '0;
        end else begin
            retire_valid_o <= wb_we; // lands with the register write
            retire_rd_o    <= mem_wb_rd;
            retire_data_o  <= wb_data;
        end
    end

    // load-use stall must keep load data out of the ex/mem forward path
    a_no_early_load_use: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(id_ex_valid && ex_mem_reg_wr && (ex_mem_wb_src == pipe_pkg::MEM) &&
          ((ex_mem_rd == id_ex_rs1) || (ex_mem_rd == id_ex_rs2))))
        else $error("load result needed in execute before it is available");

endmodule

`default_nettype wire

/* test/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int MAX_ENTRIES = 64;
localparam int NUM_GROUPS  = 6;

isa_pkg::op_e prog_op  [MAX_ENTRIES];
logic [4:0]   prog_rs1 [MAX_ENTRIES];
logic [4:0]   prog_rs2 [MAX_ENTRIES];
logic [4:0]   prog_rd  [MAX_ENTRIES];
logic [31:0]  prog_imm [MAX_ENTRIES];
logic [31:0]  prog_pc  [MAX_ENTRIES];
int           prog_grp [MAX_ENTRIES];
bit           prog_rnd [MAX_ENTRIES]; // imm replaced by a random value
int           prog_len;

task automatic add_entry(input isa_pkg::op_e op, input int rs1, input int rs2, input int rd,
                         input int imm, input int grp, input bit rnd);
    prog_op[prog_len]  = op;
    prog_rs1[prog_len] = rs1[4:0];
    prog_rs2[prog_len] = rs2[4:0];
    prog_rd[prog_len]  = rd[4:0];
    prog_imm[prog_len] = imm;
    prog_pc[prog_len]  = 32'h100 + 32'(prog_len * 4);
    prog_grp[prog_len] = grp;
    prog_rnd[prog_len] = rnd;
    prog_len++;
endtask

// entry columns are op, rs1, rs2, rd, imm, group and random imm
task automatic load_program();
    prog_len = 0;
    add_entry(isa_pkg::ADDI, 0, 0, 1, 0, 0, 1'b1);
    add_entry(isa_pkg::ADDI, 0, 0, 2, 0, 0, 1'b1);
    add_entry(isa_pkg::ADDI, 0, 0, 3, 0, 0, 1'b1);
    add_entry(isa_pkg::ADDI, 0, 0, 4, 0, 0, 1'b1);
    add_entry(isa_pkg::NOP,  0, 0, 0, 0, 0, 1'b0);
    add_entry(isa_pkg::ADD,  1, 2, 5, 0, 1, 1'b0);
    add_entry(isa_pkg::SUB,  5, 3, 6, 0, 1, 1'b0); // ex/mem on rs1
    add_entry(isa_pkg::XOR,  4, 5, 7, 0, 1, 1'b0); // mem/wb on rs2
    add_entry(isa_pkg::AND,  6, 7, 8, 0, 1, 1'b0); // both sources at once
    add_entry(isa_pkg::OR,   8, 8, 9, 0, 1, 1'b0);
    add_entry(isa_pkg::ADD,  9, 8, 10, 0, 1, 1'b0);
    add_entry(isa_pkg::NOP,  0, 0, 0, 0, 1, 1'b0);
    add_entry(isa_pkg::ADDI, 1, 0, 11, 5, 2, 1'b0);
    add_entry(isa_pkg::ADDI, 2, 0, 11, 7, 2, 1'b0);
    add_entry(isa_pkg::ADD, 11, 11, 12, 0, 2, 1'b0); // newer x11 wins
    add_entry(isa_pkg::ADDI, 3, 0, 11, 9, 2, 1'b0);
    add_entry(isa_pkg::NOP,  0, 0, 0, 0, 2, 1'b0);
    add_entry(isa_pkg::ADD, 11, 0, 13, 0, 2, 1'b0);
    add_entry(isa_pkg::SW,   0, 5, 0, 16, 3, 1'b0);
    add_entry(isa_pkg::LW,   0, 0, 14, 16, 3, 1'b0);
    add_entry(isa_pkg::ADD, 14, 1, 15, 0, 3, 1'b0); // stall on rs1
    add_entry(isa_pkg::SW,   0, 15, 0, 32, 3, 1'b0);
    add_entry(isa_pkg::LW,   0, 0, 16, 32, 3, 1'b0);
    add_entry(isa_pkg::NOP,  0, 0, 0, 0, 3, 1'b0);
    add_entry(isa_pkg::ADD, 16, 16, 17, 0, 3, 1'b0);
    add_entry(isa_pkg::LW,   0, 0, 18, 16, 3, 1'b0);
    add_entry(isa_pkg::SUB,  2, 18, 19, 0, 3, 1'b0); // stall on rs2
    add_entry(isa_pkg::NOP,  0, 0, 0, 0, 3, 1'b0);
    add_entry(isa_pkg::JAL,  0, 0, 20, 0, 4, 1'b0);
    add_entry(isa_pkg::ADD, 20, 1, 21, 0, 4, 1'b0);
    add_entry(isa_pkg::ADD, 20, 21, 22, 0, 4, 1'b0);
    add_entry(isa_pkg::NOP,  0, 0, 0, 0, 4, 1'b0);
    add_entry(isa_pkg::ADDI, 1, 0, 0, 123, 5, 1'b0);
    add_entry(isa_pkg::ADD,  0, 1, 23, 0, 5, 1'b0);
    add_entry(isa_pkg::LW,   0, 0, 0, 16, 5, 1'b0); // load to x0 needs no stall
    add_entry(isa_pkg::ADD,  0, 2, 24, 0, 5, 1'b0);
    add_entry(isa_pkg::OR,   0, 0, 25, 0, 5, 1'b0);
    add_entry(isa_pkg::NOP,  0, 0, 0, 0, 5, 1'b0);
endtask

`endif

/* test/tb_operand_pipeline.sv */
`default_nettype none

module tb_operand_pipeline;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 8;
    localparam int IDLE_CYCLES  = 4;

    logic         clk;
    logic         arst_n;
    logic         issue_valid;
    isa_pkg::op_e issue_op;
    logic [4:0]   issue_rs1, issue_rs2, issue_rd;
    logic [31:0]  issue_imm, issue_pc;
    logic         issue_stall;
    logic         retire_valid;
    logic [4:0]   retire_rd;
    logic [31:0]  retire_data;

    `include "tb_program.svh"

    logic [31:0] model_regs [32];
    logic [31:0] model_mem  [64];
    int          exp_rd[$], exp_cycle[$], exp_grp[$];
    logic [31:0] exp_data[$];
    int          group_pending [NUM_GROUPS];
    int          group_errors  [NUM_GROUPS];
    bit          group_issued  [NUM_GROUPS];
    int          cycle_cnt, timeout_limit, errors, tests_passed, tests_failed;
    int          prev_load_rd;

    operand_pipeline #(.DMEM_WORDS(64)) UUT (
        .clk_i(clk), .arst_n_i(arst_n),
        .issue_valid_i(issue_valid), .issue_op_i(issue_op),
        .issue_rs1_i(issue_rs1), .issue_rs2_i(issue_rs2), .issue_rd_i(issue_rd),
        .issue_imm_i(issue_imm), .issue_pc_i(issue_pc),
        .issue_stall_o(issue_stall), .retire_valid_o(retire_valid),
        .retire_rd_o(retire_rd), .retire_data_o(retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit) begin
            $display("timeout: pipeline did not drain within %0d cycles", timeout_limit);
            $display("Something failed");
            $finish;
        end
    end

    function automatic string group_name(input int g);
        case (g)
            0: return "register seeding";
            1: return "dependent alu forwarding";
            2: return "forward priority";
            3: return "load-use and store-load";
            4: return "jal link forwarding";
            default: return "register zero";
        endcase
    endfunction

    task automatic report_group(input int g);
        if (group_errors[g] == 0) begin
            tests_passed++;
            $display("test %0d (%s): pass", g, group_name(g));
        end else begin
            tests_failed++;
            $display("test %0d (%s): FAIL, %0d errors", g, group_name(g), group_errors[g]);
        end
    endtask

    task automatic close_group(input int g);
        group_issued[g] = 1'b1;
        if (group_pending[g] == 0) report_group(g);
    endtask

    task automatic note_error(input int g);
        errors++;
        group_errors[g]++;
    endtask

    // sequential reference that executes an entry at its acceptance edge
    task automatic model_issue(input int i, input int accept_cycle);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        bit          writes;
        a      = model_regs[prog_rs1[i]];
        b      = model_regs[prog_rs2[i]];
        addr   = a + prog_imm[i];
        writes = 1'b1;
        res    = '0;
        case (prog_op[i])
            isa_pkg::ADD:  res = a + b;
            isa_pkg::SUB:  res = a - b;
            isa_pkg::AND:  res = a & b;
            isa_pkg::OR:   res = a | b;
            isa_pkg::XOR:  res = a ^ b;
            isa_pkg::ADDI: res = addr;
            isa_pkg::LW:   res = model_mem[addr[7:2]];
            isa_pkg::JAL:  res = prog_pc[i] + 32'd4;
            isa_pkg::SW: begin
                model_mem[addr[7:2]] = b;
                writes = 1'b0;
            end
            default: writes = 1'b0;
        endcase
        if (writes && prog_rd[i] != 5'd0) begin
            model_regs[prog_rd[i]] = res;
            exp_rd.push_back(int'(prog_rd[i]));
            exp_data.push_back(res);
            exp_cycle.push_back(accept_cycle + 3);
            exp_grp.push_back(prog_grp[i]);
            group_pending[prog_grp[i]]++;
        end
        prev_load_rd = (prog_op[i] == isa_pkg::LW) ? int'(prog_rd[i]) : 0;
    endtask

    always @(negedge clk) begin
        int g;
        if (arst_n && retire_valid) begin
            if (exp_rd.size() == 0) begin
                $display("unexpected retire of x%0d at %0t ns with nothing pending",
                         retire_rd, $time);
                errors++;
            end else begin
                g = exp_grp[0];
                if (retire_rd != exp_rd[0][4:0] || retire_data != exp_data[0]) begin
                    $display("error at %0t ns: retire x%0d = %h, expected x%0d = %h",
                             $time, retire_rd, retire_data, exp_rd[0], exp_data[0]);
                    note_error(g);
                end
                if (cycle_cnt != exp_cycle[0]) begin
                    $display("error at %0t ns: retire in cycle %0d, expected cycle %0d",
                             $time, cycle_cnt, exp_cycle[0]);
                    note_error(g);
                end
                void'(exp_rd.pop_front());
                void'(exp_data.pop_front());
                void'(exp_cycle.pop_front());
                void'(exp_grp.pop_front());
                group_pending[g]--;
                if (group_pending[g] == 0 && group_issued[g]) report_group(g);
            end
        end
    end

    initial begin
        int stalls;
        int exp_stall;
        $timeformat(-9, 0, "", 0);
        cycle_cnt = 0;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        prev_load_rd = 0;
        arst_n = 1'b0;
        issue_valid = 1'b0;
        issue_op = isa_pkg::NOP;
        issue_rs1 = '0;
        issue_rs2 = '0;
        issue_rd = '0;
        issue_imm = '0;
        issue_pc = '0;
        for (int r = 0; r < 32; r++) model_regs[r] = '0;
        for (int m = 0; m < 64; m++) model_mem[m] = '0;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            group_pending[g] = 0;
            group_errors[g] = 0;
            group_issued[g] = 1'b0;
        end
        void'($urandom(38));
        load_program();
        for (int i = 0; i < prog_len; i++) begin
            if (prog_rnd[i]) prog_imm[i] = $urandom;
        end
        timeout_limit = RESET_CYCLES + IDLE_CYCLES + 2 * prog_len + 20;

        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            if (retire_valid || issue_stall) begin
                $display("error at %0t ns: retire or stall active before first issue", $time);
                errors++;
            end
        end

        for (int i = 0; i < prog_len; i++) begin
            @(negedge clk);
            if (i > 0 && prog_grp[i] != prog_grp[i-1]) close_group(prog_grp[i-1]);
            issue_valid = 1'b1;
            issue_op = prog_op[i];
            issue_rs1 = prog_rs1[i];
            issue_rs2 = prog_rs2[i];
            issue_rd = prog_rd[i];
            issue_imm = prog_imm[i];
            issue_pc = prog_pc[i];
            exp_stall = (prev_load_rd != 0 && (int'(prog_rs1[i]) == prev_load_rd ||
                         int'(prog_rs2[i]) == prev_load_rd)) ? 1 : 0;
            stalls = 0;
            #1;
            while (issue_stall) begin // fields held
                stalls++;
                @(negedge clk);
                #1;
            end
            if (stalls != exp_stall) begin
                $display("error at %0t ns: entry %0d stalled %0d cycles, expected %0d",
                         $time, i, stalls, exp_stall);
                note_error(prog_grp[i]);
            end
            model_issue(i, cycle_cnt + 1);
        end
        @(negedge clk);
        issue_valid = 1'b0;
        issue_op = isa_pkg::NOP;
        close_group(prog_grp[prog_len-1]);

        repeat (4) @(negedge clk); // last retire is due three cycles after acceptance
        if (exp_rd.size() != 0) begin
            $display("%0d expected retires never arrived", exp_rd.size());
            errors++;
        end
        $display("tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+test
source/isa_pkg.sv
source/pipe_pkg.sv
source/reg_file.sv
source/load_use_guard.sv
source/forward_controller.sv
source/exec_unit.sv
source/data_mem.sv
source/operand_pipeline.sv
test/tb_operand_pipeline.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the operand pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Something failed"

verilator --binary --timing --assert -f filelist.f \
    --top-module tb_operand_pipeline -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
    exit 1
fi

exit 0
